//--- src/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

    // Image geometry
    localparam int IMG_WIDTH    = 8;
    localparam int KERNEL_SIZE  = 3;
    localparam int OUT_WIDTH    = IMG_WIDTH - KERNEL_SIZE + 1;

    // Parallel kernel copies, each owning one column segment
    localparam int NUM_KERNELS  = 2;
    localparam int SEG_WIDTH    = IMG_WIDTH / NUM_KERNELS;

    // Channel counts
    localparam int IN_CHANNELS  = 2;
    localparam int OUT_CHANNELS = 2;

    // Data widths, weights are unsigned fixed point with WEIGHT_Q_SHIFT fraction bits
    localparam int VALUE_BITS     = 8;
    localparam int WEIGHT_BITS    = 8;
    localparam int WEIGHT_Q_SHIFT = 4;
    localparam int PROD_BITS      = VALUE_BITS + WEIGHT_BITS;
    localparam int TAG_WIDTH      = 4;

    // Counter widths
    localparam int COL_IDX_BITS = $clog2(SEG_WIDTH + 1);
    localparam int OCH_IDX_BITS = (OUT_CHANNELS > 1) ? $clog2(OUT_CHANNELS) : 1;
    // Holds KERNEL_SIZE-1, the count at which the window is full
    localparam int ROW_CNT_BITS = $clog2(KERNEL_SIZE);

    // Controller FSM encoding
    localparam int                    STATE_BITS = 2;
    localparam logic [STATE_BITS-1:0] ST_FETCH   = 2'd0;
    localparam logic [STATE_BITS-1:0] ST_COMPUTE = 2'd1;
    localparam logic [STATE_BITS-1:0] ST_WAIT    = 2'd2;

endpackage

`default_nettype wire

//--- src/row_window_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module row_window_buffer (
    input  wire                             clock_i,
    // Load strobe, same cycle as the row handshake
    input  wire                             shift_row_i,
    input  wire  [cnn_pkg::VALUE_BITS-1:0]  next_row_i [cnn_pkg::IMG_WIDTH]
                                                       [cnn_pkg::IN_CHANNELS],
    // Horizontal kernel position inside each segment
    input  wire  [cnn_pkg::COL_IDX_BITS-1:0] col_idx_i,
    output logic [cnn_pkg::VALUE_BITS-1:0]  taps_o [cnn_pkg::NUM_KERNELS]
                                                   [cnn_pkg::IN_CHANNELS]
                                                   [cnn_pkg::KERNEL_SIZE]
                                                   [cnn_pkg::KERNEL_SIZE]
);

    // Row 0 is the oldest, row KERNEL_SIZE-1 the newest
    logic [cnn_pkg::VALUE_BITS-1:0] rows_q [cnn_pkg::KERNEL_SIZE]
                                           [cnn_pkg::IMG_WIDTH]
                                           [cnn_pkg::IN_CHANNELS];

    // Vertical shift, whole rows move up one place
    always_ff @(posedge clock_i) begin
        if (shift_row_i) begin
            for (int r = 0; r < cnn_pkg::KERNEL_SIZE - 1; r++) begin
                rows_q[r] <= rows_q[r + 1];
            end
            // New row enters at the bottom
            rows_q[cnn_pkg::KERNEL_SIZE - 1] <= next_row_i;
        end
    end

    // Column-offset mux feeding every kernel copy
    always_comb begin
        int col;
        col = 0;
        for (int k = 0; k < cnn_pkg::NUM_KERNELS; k++) begin
            for (int ch = 0; ch < cnn_pkg::IN_CHANNELS; ch++) begin
                for (int dy = 0; dy < cnn_pkg::KERNEL_SIZE; dy++) begin
                    for (int dx = 0; dx < cnn_pkg::KERNEL_SIZE; dx++) begin
                        // Absolute image column under this tap
                        col = k * cnn_pkg::SEG_WIDTH + int'(col_idx_i) + dx;
                        // Past the right edge the tap reads zero
                        if (col < cnn_pkg::IMG_WIDTH) begin
                            taps_o[k][ch][dy][dx] = rows_q[dy][col][ch];
                        end else begin
                            taps_o[k][ch][dy][dx] = '0;
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/kernel_mac_array.sv
`timescale 1ns/100ps
`default_nettype none

module kernel_mac_array (
    // One output channel's kernel, shared by all copies
    input  wire  [cnn_pkg::WEIGHT_BITS-1:0] weights_i [cnn_pkg::IN_CHANNELS]
                                                      [cnn_pkg::KERNEL_SIZE]
                                                      [cnn_pkg::KERNEL_SIZE],
    // Tap windows, one per kernel copy
    input  wire  [cnn_pkg::VALUE_BITS-1:0]  taps_i [cnn_pkg::NUM_KERNELS]
                                                   [cnn_pkg::IN_CHANNELS]
                                                   [cnn_pkg::KERNEL_SIZE]
                                                   [cnn_pkg::KERNEL_SIZE],
    // One result pixel per copy, same cycle
    output logic [cnn_pkg::VALUE_BITS-1:0]  sums_o [cnn_pkg::NUM_KERNELS]
);

    // Unsigned dot product per copy
    always_comb begin
        logic [cnn_pkg::PROD_BITS-1:0]  prod;
        logic [cnn_pkg::PROD_BITS-1:0]  scaled;
        logic [cnn_pkg::VALUE_BITS-1:0] acc;
        prod   = '0;
        scaled = '0;
        acc    = '0;
        for (int k = 0; k < cnn_pkg::NUM_KERNELS; k++) begin
            acc = '0;
            for (int ch = 0; ch < cnn_pkg::IN_CHANNELS; ch++) begin
                for (int dy = 0; dy < cnn_pkg::KERNEL_SIZE; dy++) begin
                    for (int dx = 0; dx < cnn_pkg::KERNEL_SIZE; dx++) begin
                        // Full-width product, no overflow here
                        prod = weights_i[ch][dy][dx] * taps_i[k][ch][dy][dx];
                        // Drop the weight fraction bits per term
                        scaled = prod >> cnn_pkg::WEIGHT_Q_SHIFT;
                        // Accumulator wraps modulo 2**VALUE_BITS
                        acc = acc + scaled[cnn_pkg::VALUE_BITS-1:0];
                    end
                end
            end
            sums_o[k] = acc;
        end
    end

endmodule

`default_nettype wire

//--- src/conv_row_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module conv_row_ctrl (
    input  wire                              clock_i,
    input  wire                              reset_i,
    // Input row handshake
    input  wire                              in_row_valid_i,
    input  wire                              in_row_last_i,
    input  wire  [cnn_pkg::TAG_WIDTH-1:0]    in_row_tag_i,
    output logic                             in_row_accept_o,
    // Datapath control
    output logic                             shift_row_o,
    output logic [cnn_pkg::COL_IDX_BITS-1:0] col_idx_o,
    output logic [cnn_pkg::OCH_IDX_BITS-1:0] och_idx_o,
    input  wire  [cnn_pkg::VALUE_BITS-1:0]   sums_i [cnn_pkg::NUM_KERNELS],
    // Output row handshake
    output logic [cnn_pkg::VALUE_BITS-1:0]   out_row_o [cnn_pkg::OUT_WIDTH]
                                                       [cnn_pkg::OUT_CHANNELS],
    output logic                             out_row_valid_o,
    output logic                             out_row_last_o,
    output logic [cnn_pkg::TAG_WIDTH-1:0]    out_row_tag_o,
    input  wire                              out_row_accept_i
);

    // Control state
    logic [cnn_pkg::STATE_BITS-1:0]   state_q;
    logic [cnn_pkg::ROW_CNT_BITS-1:0] row_cnt_q;
    logic [cnn_pkg::COL_IDX_BITS-1:0] col_q;
    logic [cnn_pkg::OCH_IDX_BITS-1:0] och_q;
    logic                             out_valid_q;

    // Output row payload
    logic [cnn_pkg::VALUE_BITS-1:0] out_row_q [cnn_pkg::OUT_WIDTH][cnn_pkg::OUT_CHANNELS];
    logic                           out_last_q;
    logic [cnn_pkg::TAG_WIDTH-1:0]  out_tag_q;

    // Window already holds KERNEL_SIZE-1 rows, next row completes it
    logic window_full;
    logic last_och;
    logic last_col;

    assign window_full = (row_cnt_q == cnn_pkg::KERNEL_SIZE - 1);
    assign last_och    = (och_q == cnn_pkg::OUT_CHANNELS - 1);
    assign last_col    = (col_q == cnn_pkg::SEG_WIDTH - 1);

    // Accept only while fetching, straight from valid
    assign in_row_accept_o = (state_q == cnn_pkg::ST_FETCH) && in_row_valid_i;
    // Buffer loads on the handshake edge
    assign shift_row_o     = in_row_accept_o;
    assign col_idx_o       = col_q;
    assign och_idx_o       = och_q;

    assign out_row_o       = out_row_q;
    assign out_row_valid_o = out_valid_q;
    assign out_row_last_o  = out_last_q;
    assign out_row_tag_o   = out_tag_q;

    // FSM, channel steps fastest, then column
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q     <= cnn_pkg::ST_FETCH;
            row_cnt_q   <= '0;
            col_q       <= '0;
            och_q       <= '0;
            out_valid_q <= 1'b0;
        end else begin
            case (state_q)
                cnn_pkg::ST_FETCH: begin
                    if (in_row_accept_o) begin
                        col_q <= '0;
                        och_q <= '0;
                        if (window_full) begin
                            state_q <= cnn_pkg::ST_COMPUTE;
                        end else if (in_row_last_i) begin
                            // Image ended before the window filled
                            row_cnt_q <= '0;
                        end else begin
                            row_cnt_q <= row_cnt_q + 1'b1;
                        end
                    end
                end
                cnn_pkg::ST_COMPUTE: begin
                    if (last_och) begin
                        och_q <= '0;
                        if (last_col) begin
                            // Row complete on this edge
                            col_q       <= '0;
                            state_q     <= cnn_pkg::ST_WAIT;
                            out_valid_q <= 1'b1;
                        end else begin
                            col_q <= col_q + 1'b1;
                        end
                    end else begin
                        och_q <= och_q + 1'b1;
                    end
                end
                cnn_pkg::ST_WAIT: begin
                    if (out_row_accept_i) begin
                        out_valid_q <= 1'b0;
                        state_q     <= cnn_pkg::ST_FETCH;
                        // New image starts with an empty window
                        if (out_last_q) begin
                            row_cnt_q <= '0;
                        end
                    end
                end
                default: begin
                    state_q <= cnn_pkg::ST_FETCH;
                end
            endcase
        end
    end

    // Tag, last flag and result pixels
    always_ff @(posedge clock_i) begin
        int pix;
        pix = 0;
        if (in_row_accept_o) begin
            out_tag_q  <= in_row_tag_i;
            out_last_q <= in_row_last_i;
        end
        if (state_q == cnn_pkg::ST_COMPUTE) begin
            for (int k = 0; k < cnn_pkg::NUM_KERNELS; k++) begin
                pix = k * cnn_pkg::SEG_WIDTH + int'(col_q);
                // Columns past OUT_WIDTH overhang the image edge
                if (pix < cnn_pkg::OUT_WIDTH) begin
                    out_row_q[pix][och_q] <= sums_i[k];
                end
            end
        end
    end

    // Pending output row holds every pixel until taken
    for (genvar x = 0; x < cnn_pkg::OUT_WIDTH; x++) begin : g_hold_x
        for (genvar o = 0; o < cnn_pkg::OUT_CHANNELS; o++) begin : g_hold_o
            a_pixel_hold: assert property (@(posedge clock_i) disable iff (reset_i)
                out_valid_q && !out_row_accept_i |=> $stable(out_row_q[x][o]));
        end
    end

    a_row_hold: assert property (@(posedge clock_i) disable iff (reset_i)
        out_valid_q && !out_row_accept_i |=>
            out_valid_q && $stable(out_tag_q) && $stable(out_last_q));

    // One row in flight, so no input while an output row waits
    a_accept_rule: assert property (@(posedge clock_i) disable iff (reset_i)
        in_row_accept_o |-> in_row_valid_i && !out_valid_q);

    a_col_range: assert property (@(posedge clock_i) disable iff (reset_i)
        col_q < cnn_pkg::SEG_WIDTH);

endmodule

`default_nettype wire

//--- src/conv_layer_top.sv
`timescale 1ns/100ps
`default_nettype none

module conv_layer_top (
    input  wire                             clock_i,
    input  wire                             reset_i,
    // Layer configuration, constant during a run
    input  wire  [cnn_pkg::WEIGHT_BITS-1:0] weights_i [cnn_pkg::OUT_CHANNELS]
                                                      [cnn_pkg::IN_CHANNELS]
                                                      [cnn_pkg::KERNEL_SIZE]
                                                      [cnn_pkg::KERNEL_SIZE],
    // Input rows
    input  wire  [cnn_pkg::VALUE_BITS-1:0]  in_row_i [cnn_pkg::IMG_WIDTH]
                                                     [cnn_pkg::IN_CHANNELS],
    input  wire                             in_row_valid_i,
    input  wire                             in_row_last_i,
    input  wire  [cnn_pkg::TAG_WIDTH-1:0]   in_row_tag_i,
    output logic                            in_row_accept_o,
    // Output rows
    output logic [cnn_pkg::VALUE_BITS-1:0]  out_row_o [cnn_pkg::OUT_WIDTH]
                                                      [cnn_pkg::OUT_CHANNELS],
    output logic                            out_row_valid_o,
    output logic                            out_row_last_o,
    output logic [cnn_pkg::TAG_WIDTH-1:0]   out_row_tag_o,
    input  wire                             out_row_accept_i
);

    logic                             shift_row;
    logic [cnn_pkg::COL_IDX_BITS-1:0] col_idx;
    logic [cnn_pkg::OCH_IDX_BITS-1:0] och_idx;
    logic [cnn_pkg::VALUE_BITS-1:0]   taps [cnn_pkg::NUM_KERNELS]
                                           [cnn_pkg::IN_CHANNELS]
                                           [cnn_pkg::KERNEL_SIZE]
                                           [cnn_pkg::KERNEL_SIZE];
    logic [cnn_pkg::VALUE_BITS-1:0]   sums [cnn_pkg::NUM_KERNELS];
    logic [cnn_pkg::WEIGHT_BITS-1:0]  och_weights [cnn_pkg::IN_CHANNELS]
                                                  [cnn_pkg::KERNEL_SIZE]
                                                  [cnn_pkg::KERNEL_SIZE];

    // Kernel of the output channel being computed this cycle
    assign och_weights = weights_i[och_idx];

    row_window_buffer u_window (
        .clock_i     (clock_i),
        .shift_row_i (shift_row),
        .next_row_i  (in_row_i),
        .col_idx_i   (col_idx),
        .taps_o      (taps)
    );

    kernel_mac_array u_mac (
        .weights_i (och_weights),
        .taps_i    (taps),
        .sums_o    (sums)
    );

    conv_row_ctrl u_ctrl (
        .clock_i          (clock_i),
        .reset_i          (reset_i),
        .in_row_valid_i   (in_row_valid_i),
        .in_row_last_i    (in_row_last_i),
        .in_row_tag_i     (in_row_tag_i),
        .in_row_accept_o  (in_row_accept_o),
        .shift_row_o      (shift_row),
        .col_idx_o        (col_idx),
        .och_idx_o        (och_idx),
        .sums_i           (sums),
        .out_row_o        (out_row_o),
        .out_row_valid_o  (out_row_valid_o),
        .out_row_last_o   (out_row_last_o),
        .out_row_tag_o    (out_row_tag_o),
        .out_row_accept_i (out_row_accept_i)
    );

endmodule

`default_nettype wire

//--- verification/conv_layer_tb.sv
`timescale 1ns/100ps
`default_nettype none

module conv_layer_tb;

    logic                            clock;
    logic                            reset;
    logic [cnn_pkg::WEIGHT_BITS-1:0] weights [cnn_pkg::OUT_CHANNELS][cnn_pkg::IN_CHANNELS]
                                             [cnn_pkg::KERNEL_SIZE][cnn_pkg::KERNEL_SIZE];
    logic [cnn_pkg::VALUE_BITS-1:0]  in_row [cnn_pkg::IMG_WIDTH][cnn_pkg::IN_CHANNELS];
    logic                            in_valid;
    logic                            in_last;
    logic [cnn_pkg::TAG_WIDTH-1:0]   in_tag;
    logic                            in_accept;
    logic [cnn_pkg::VALUE_BITS-1:0]  out_row [cnn_pkg::OUT_WIDTH][cnn_pkg::OUT_CHANNELS];
    logic                            out_valid;
    logic                            out_last;
    logic [cnn_pkg::TAG_WIDTH-1:0]   out_tag;
    logic                            out_accept;

    // Whole data file as one byte per hex word
    logic [7:0]  test_mem [0:255];
    int          num_in;
    int          num_out;
    int          rows_sent   = 0;
    int          rows_seen   = 0;
    int          cycle_cnt   = 0;
    int          cycle_limit = 1000;
    logic [31:0] lcg_state;

    conv_layer_top UUT (
        .clock_i          (clock),
        .reset_i          (reset),
        .weights_i        (weights),
        .in_row_i         (in_row),
        .in_row_valid_i   (in_valid),
        .in_row_last_i    (in_last),
        .in_row_tag_i     (in_tag),
        .in_row_accept_o  (in_accept),
        .out_row_o        (out_row),
        .out_row_valid_o  (out_valid),
        .out_row_last_o   (out_last),
        .out_row_tag_o    (out_tag),
        .out_row_accept_i (out_accept)
    );

    always #5 clock = ~clock;

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "%s", what);
    endtask

    task automatic check_pixel(input string name, input logic [cnn_pkg::VALUE_BITS-1:0] got,
                               input logic [cnn_pkg::VALUE_BITS-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_tag(input string name, input logic [cnn_pkg::TAG_WIDTH-1:0] got,
                             input logic [cnn_pkg::TAG_WIDTH-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // Sink accept pattern
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Word address inside an input row past the two counts and all weights
    function automatic int row_word(input int row, input int w);
        return 2 + cnn_pkg::OUT_CHANNELS * cnn_pkg::IN_CHANNELS * cnn_pkg::KERNEL_SIZE
                 * cnn_pkg::KERNEL_SIZE + row * (cnn_pkg::IMG_WIDTH * cnn_pkg::IN_CHANNELS + 2) + w;
    endfunction

    // Expected rows follow the last input row
    function automatic int expect_word(input int row, input int w);
        return row_word(num_in, 0) + row * (cnn_pkg::OUT_WIDTH * cnn_pkg::OUT_CHANNELS + 2) + w;
    endfunction

    // Run limit grows with the test length
    always @(posedge clock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            stop_on_error($sformatf("Timeout after %0d cycles with %0d of %0d rows checked",
                                    cycle_cnt, rows_seen, num_out));
        end
    end

    // Protocol watch at mid-cycle where every signal is settled
    always @(negedge clock) begin
        if (!reset) begin
            if (in_accept && !in_valid) begin
                stop_on_error("Input accept raised without a valid row");
            end
            // No output before the first window of the run is full
            if (out_valid && rows_sent < cnn_pkg::KERNEL_SIZE) begin
                stop_on_error("Output row valid before the window filled");
            end
        end
    end

    task automatic send_rows();
        int npix;
        npix = cnn_pkg::IMG_WIDTH * cnn_pkg::IN_CHANNELS;
        for (int i = 0; i < num_in; i++) begin
            for (int x = 0; x < cnn_pkg::IMG_WIDTH; x++) begin
                for (int ch = 0; ch < cnn_pkg::IN_CHANNELS; ch++) begin
                    in_row[x][ch] = test_mem[row_word(i, x * cnn_pkg::IN_CHANNELS + ch)];
                end
            end
            in_last  = test_mem[row_word(i, npix)][0];
            in_tag   = test_mem[row_word(i, npix + 1)][cnn_pkg::TAG_WIDTH-1:0];
            in_valid = 1'b1;
            // Row held until the layer takes it
            do begin
                @(negedge clock);
            end while (!in_accept);
            @(posedge clock);
            #1;
            rows_sent++;
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_rows();
        logic [cnn_pkg::VALUE_BITS-1:0] held_row [cnn_pkg::OUT_WIDTH][cnn_pkg::OUT_CHANNELS];
        logic [cnn_pkg::TAG_WIDTH-1:0]  held_tag;
        logic                           held_last;
        logic                           pending;
        int                             npix;
        int                             idx;
        pending = 1'b0;
        npix    = cnn_pkg::OUT_WIDTH * cnn_pkg::OUT_CHANNELS;
        while (rows_seen < num_out) begin
            @(posedge clock);
            #1;
            lcg_state  = lcg_next(lcg_state);
            out_accept = lcg_state[20];
            @(negedge clock);
            // A refused row must come back unchanged
            if (pending) begin
                if (!out_valid) begin
                    stop_on_error("Output row withdrawn before it was accepted");
                end
                for (int x = 0; x < cnn_pkg::OUT_WIDTH; x++) begin
                    for (int o = 0; o < cnn_pkg::OUT_CHANNELS; o++) begin
                        check_pixel($sformatf("out_row_o[%0d][%0d] held", x, o),
                                    out_row[x][o], held_row[x][o]);
                    end
                end
                check_tag("out_row_tag_o held", out_tag, held_tag);
                check_flag("out_row_last_o held", out_last, held_last);
            end
            if (out_valid && out_accept) begin
                for (int x = 0; x < cnn_pkg::OUT_WIDTH; x++) begin
                    for (int o = 0; o < cnn_pkg::OUT_CHANNELS; o++) begin
                        idx = expect_word(rows_seen, x * cnn_pkg::OUT_CHANNELS + o);
                        check_pixel($sformatf("out_row_o[%0d][%0d]", x, o),
                                    out_row[x][o], test_mem[idx]);
                    end
                end
                check_flag("out_row_last_o", out_last, test_mem[expect_word(rows_seen, npix)][0]);
                idx = expect_word(rows_seen, npix + 1);
                check_tag("out_row_tag_o", out_tag, test_mem[idx][cnn_pkg::TAG_WIDTH-1:0]);
                rows_seen++;
                pending = 1'b0;
            end else if (out_valid) begin
                held_row  = out_row;
                held_tag  = out_tag;
                held_last = out_last;
                pending   = 1'b1;
            end
        end
        @(posedge clock);
        #1;
        out_accept = 1'b0;
    endtask

    initial begin
        clock      = 1'b0;
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_last    = 1'b0;
        in_tag     = '0;
        out_accept = 1'b0;
        in_row     = '{default: '0};
        weights    = '{default: '0};
        lcg_state  = 32'h28076692;
        $readmemh("verification/conv_tests.txt", test_mem);
        num_in  = test_mem[0];
        num_out = test_mem[1];
        if (num_in == 0 || num_out == 0) begin
            stop_on_error("Data file holds no rows");
        end
        cycle_limit = 20 * (num_in + num_out) + 100;
        // Weights come first in [out ch][in ch][dy][dx] order
        for (int o = 0; o < cnn_pkg::OUT_CHANNELS; o++) begin
            for (int ch = 0; ch < cnn_pkg::IN_CHANNELS; ch++) begin
                for (int dy = 0; dy < cnn_pkg::KERNEL_SIZE; dy++) begin
                    for (int dx = 0; dx < cnn_pkg::KERNEL_SIZE; dx++) begin
                        weights[o][ch][dy][dx] = test_mem[2 + ((o * cnn_pkg::IN_CHANNELS + ch)
                            * cnn_pkg::KERNEL_SIZE + dy) * cnn_pkg::KERNEL_SIZE + dx];
                    end
                end
            end
        end
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        // Idle with valid low while accept must stay low
        repeat (3) @(posedge clock);
        #1;
        fork
            send_rows();
            collect_rows();
        join
        // Quiet tail catches a duplicated row
        repeat (20) begin
            @(negedge clock);
            if (out_valid) begin
                stop_on_error("Unexpected extra output row");
            end
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/conv_tests.txt
// Counts (input rows, expected rows), then weights [out ch][in ch][dy][dx] nine per line
// Input rows: pixels [x][ch], last, tag. Expected rows: pixels [x][out ch], last, tag
07 03
10 00 00 00 00 00 00 00 20
00 00 00 00 08 00 00 00 00
00 00 18 00 00 00 00 00 00
10 10 10 10 10 10 10 10 10
// Image A, ramp pixels
10 01 11 04 12 07 13 0A 14 0D 15 10 16 13 17 16 0 1
20 03 21 06 22 09 23 0C 24 0F 25 12 26 15 27 18 0 2
30 05 31 08 32 0B 33 0E 34 11 35 14 36 17 37 1A 0 3
40 07 41 0A 42 0D 43 10 44 13 45 16 46 19 47 1C 1 4
// Image B, large pixels whose sums wrap
C0 FA C1 F7 C2 F4 C3 F1 C4 EE C5 EB C6 E8 C7 E5 0 9
D0 F8 D1 F5 D2 F2 D3 EF D4 EC D5 E9 D6 E6 D7 E3 0 A
E0 F6 E1 F3 E2 F0 E3 ED E4 EA E5 E7 E6 E4 E7 E1 1 B
// Expected output rows
77 51 7B 6D 80 8A 84 A6 89 C3 8D DF 0 3
A8 7B AC 97 B1 B4 B5 D0 BA ED BE 09 1 4
FE C0 00 A6 01 8D 03 73 04 5A 06 40 1 B

//--- vlog.f
src/cnn_pkg.sv
src/row_window_buffer.sv
src/kernel_mac_array.sv
src/conv_row_ctrl.sv
src/conv_layer_top.sv
verification/conv_layer_tb.sv

//--- Makefile
# Verilator build and run of the convolution layer testbench

VERILATOR ?= verilator
TOP       ?= conv_layer_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= STATUS: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
